// ==== src.f ====
common/dma_pkg.sv
common/tcdm_pkg.sv
src/dma_req_cut.sv
src/dma/dma_split_midend.sv
src/dma/dma_distributed_midend.sv
src/dma_cluster_frontend.sv
test/dma_frontend_properties.sv
test/tb_dma_cluster_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP       := tb_dma_cluster_frontend
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_dma_cluster_frontend.sv ====
// Testbench for the DMA front end, with behavioral group models on the group ports.
// Random TCDM addresses keep 1 KiB clear of the TCDM end so no burst leaves it.
module tb_dma_cluster_frontend
  import dma_pkg::*;
  import tcdm_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [AddrWidth-1:0] TcdmBase = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] TcdmSize = 32'h0001_0000;
  localparam int unsigned FifoDepth   = 8;
  localparam int unsigned Seed        = 32'hfab5;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned NumDirected = 4;
  localparam int unsigned NumRandom   = 40;
  localparam int unsigned MaxCycles   = 200 * (NumDirected + NumRandom) + ResetCycles;

  logic clk_i, reset_i, req_valid_i, req_ready_o, trans_complete_o, backend_idle_o;
  logic [AddrWidth-1:0] src_addr_i, dst_addr_i;
  logic [LenWidth-1:0]  num_bytes_i;
  logic [NumGroups-1:0][AddrWidth-1:0] grp_src_addr_o, grp_dst_addr_o;
  logic [NumGroups-1:0][LenWidth-1:0]  grp_num_bytes_o;
  logic [NumGroups-1:0] grp_valid_o, grp_ready_i, grp_done_i;

  // Expected sub-bursts per group, packed as {src, dst, num_bytes}
  logic [BurstWidth-1:0] exp_q [NumGroups][$];
  int unsigned accepted [NumGroups] = '{default: 0};
  int unsigned sent, completions, tests, checks, errors, cycles;

  dma_cluster_frontend #(
    .TCDMBaseAddr  (TcdmBase ),
    .TCDMSize      (TcdmSize ),
    .TransFifoDepth(FifoDepth)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic bit in_tcdm(input logic [AddrWidth-1:0] addr);
    return (addr >= TcdmBase) && (33'(addr) < 33'(TcdmBase) + 33'(TcdmSize));
  endfunction

  // Walks the burst in chunks that end at every group window edge of the TCDM side
  function automatic void expand_request(input logic [AddrWidth-1:0] src, dst,
                                         input logic [LenWidth-1:0] len);
    logic [AddrWidth-1:0] s, d, t;
    int unsigned rest, chunk, g;
    bit dst_side;
    dst_side = in_tcdm(dst);
    if (!dst_side && !in_tcdm(src)) begin
      exp_q[0].push_back({src, dst, len});
      return;
    end
    s = src;
    d = dst;
    rest = 32'(len);
    while (rest > 0) begin
      t = dst_side ? d : s;
      chunk = GroupRegionBytes - (t % GroupRegionBytes);
      if (chunk > rest) begin
        chunk = rest;
      end
      g = (t / GroupRegionBytes) % NumGroups;
      exp_q[g].push_back({s, d, LenWidth'(chunk)});
      s += chunk;
      d += chunk;
      rest -= chunk;
    end
  endfunction

  task automatic check_value(input string what, input logic [BurstWidth-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %0s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic send_request(input logic [AddrWidth-1:0] src, dst,
                              input logic [LenWidth-1:0] len);
    expand_request(src, dst, len);
    sent++;
    src_addr_i  = src;
    dst_addr_i  = dst;
    num_bytes_i = len;
    req_valid_i = 1'b1;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int unsigned left;
    do @(negedge clk_i); while (completions < sent || !backend_idle_o);
    left = 0;
    for (int g = 0; g < NumGroups; g++) begin
      left += exp_q[g].size();
    end
    check_value({name, " completions"}, completions, sent);
    check_value({name, " sub-bursts still expected"}, left, 0);
    tests++;
    $display("Test %0s finished, %0d errors so far", name, errors);
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic [AddrWidth-1:0] random_addr();
    if ($urandom_range(1) == 1) begin
      return TcdmBase + ($urandom % (TcdmSize - 1024));
    end
    return 32'h8000_0000 | ($urandom & 32'h0fff_ffff);
  endfunction

  // Group models: random ready, in-order done after a random delay
  initial begin
    int unsigned done_sent [NumGroups];
    int unsigned done_wait [NumGroups];
    grp_ready_i = '0;
    grp_done_i  = '0;
    for (int g = 0; g < NumGroups; g++) begin
      done_sent[g] = 0;
      done_wait[g] = 0;
    end
    forever begin
      @(posedge clk_i);
      #1;
      grp_done_i = '0;
      for (int g = 0; g < NumGroups; g++) begin
        grp_ready_i[g] = ($urandom_range(3) != 0);
        if (accepted[g] > done_sent[g]) begin
          if (done_wait[g] == 0) begin
            grp_done_i[g] = 1'b1;
            done_sent[g]++;
            done_wait[g] = $urandom_range(5);
          end else begin
            done_wait[g]--;
          end
        end
      end
    end
  end

  // Compares every group transfer with the head of that group's expected queue
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (trans_complete_o) begin
        completions++;
      end
      for (int g = 0; g < NumGroups; g++) begin
        if (grp_valid_o[g] && grp_ready_i[g]) begin
          accepted[g]++;
          if (exp_q[g].size() == 0) begin
            errors++;
            $display("Error at %0t: group %0d got a sub-burst that no request asked for",
                     $time, g);
          end else begin
            check_value($sformatf("group %0d sub-burst", g),
                        {grp_src_addr_o[g], grp_dst_addr_o[g], grp_num_bytes_o[g]},
                        exp_q[g].pop_front());
          end
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(Seed));
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    src_addr_i  = '0;
    dst_addr_i  = '0;
    num_bytes_i = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("backend_idle_o after reset", backend_idle_o, 1);
    check_value("grp_valid_o after reset", grp_valid_o, 0);
    check_value("trans_complete_o after reset", trans_complete_o, 0);
    tests++;
    $display("Test reset_state finished, %0d errors so far", errors);
    @(posedge clk_i);
    #1;
    send_request(32'h8000_0000, 32'h0000_0044, 16);
    finish_test("single_window");
    send_request(32'h9000_0000, 32'h0000_00f0, 96);
    finish_test("region_cross");
    send_request(32'h0000_0230, 32'h8000_1000, 200);
    send_request(32'h8000_0000, 32'h9000_0000, 300);
    finish_test("src_side_and_no_tcdm");
    for (int i = 0; i < NumRandom; i++) begin
      send_request(random_addr(), random_addr(), LenWidth'($urandom_range(600, 1)));
    end
    finish_test("random_back_to_back");
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== test/dma_frontend_properties.sv ====
// Handshake and meta assertions on the DMA front end ports.
// Bound into every dma_cluster_frontend, port names follow the DUT.
module dma_frontend_properties
  import dma_pkg::*;
  import tcdm_pkg::*;
(
  input logic                                 clk_i,
  input logic                                 reset_i,
  input logic [AddrWidth-1:0]                 src_addr_i,
  input logic [AddrWidth-1:0]                 dst_addr_i,
  input logic [LenWidth-1:0]                  num_bytes_i,
  input logic                                 req_valid_i,
  input logic                                 req_ready_o,
  input logic [NumGroups-1:0][AddrWidth-1:0] grp_src_addr_o,
  input logic [NumGroups-1:0][AddrWidth-1:0] grp_dst_addr_o,
  input logic [NumGroups-1:0][LenWidth-1:0]  grp_num_bytes_o,
  input logic [NumGroups-1:0]                 grp_valid_o,
  input logic [NumGroups-1:0]                 grp_ready_i,
  input logic                                 trans_complete_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Requests accepted and not yet completed
  int unsigned open_cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      open_cnt_q <= 0;
    end else begin
      open_cnt_q <= open_cnt_q + 32'(req_valid_i && req_ready_o) - 32'(trans_complete_o);
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i && !req_ready_o |=> req_valid_i && $stable({src_addr_i, dst_addr_i, num_bytes_i}))
    else $error("Request withdrawn or changed before it was accepted");

  assert property (@(posedge clk_i) disable iff (reset_i) req_valid_i |-> num_bytes_i != '0)
    else $error("Request with zero length");

  assert property (@(posedge clk_i) disable iff (reset_i) trans_complete_o |-> open_cnt_q != 0)
    else $error("Completion without an open request");

  // Back-to-back pulses only when a further request is open
  assert property (@(posedge clk_i) disable iff (reset_i)
    trans_complete_o && open_cnt_q == 1 |=> !trans_complete_o)
    else $error("Completion pulse longer than one cycle");

  for (genvar g = 0; g < NumGroups; g++) begin : gen_grp
    assert property (@(posedge clk_i) disable iff (reset_i)
      grp_valid_o[g] && !grp_ready_i[g] |=> grp_valid_o[g]
        && $stable({grp_src_addr_o[g], grp_dst_addr_o[g], grp_num_bytes_o[g]}))
      else $error("Group %0d sub-burst withdrawn or changed before it was accepted", g);
  end

endmodule

bind dma_cluster_frontend dma_frontend_properties i_properties (.*);

// ==== src/dma_cluster_frontend.sv ====
// Cluster DMA front end, from burst request to per-group sub-bursts.
// TCDMBaseAddr must be ClusterRegionBytes-aligned. Zero-length requests are illegal.
module dma_cluster_frontend
  import dma_pkg::*;
  import tcdm_pkg::*;
#(
  parameter logic [AddrWidth-1:0] TCDMBaseAddr   = 32'h0000_0000,
  parameter logic [AddrWidth-1:0] TCDMSize       = 32'h0001_0000,
  parameter int unsigned          TransFifoDepth = 8
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [AddrWidth-1:0]                 src_addr_i,
  input  logic [AddrWidth-1:0]                 dst_addr_i,
  input  logic [LenWidth-1:0]                  num_bytes_i,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  output logic [NumGroups-1:0][AddrWidth-1:0] grp_src_addr_o,
  output logic [NumGroups-1:0][AddrWidth-1:0] grp_dst_addr_o,
  output logic [NumGroups-1:0][LenWidth-1:0]  grp_num_bytes_o,
  output logic [NumGroups-1:0]                 grp_valid_o,
  input  logic [NumGroups-1:0]                 grp_ready_i,
  input  logic [NumGroups-1:0]                 grp_done_i,
  output logic                                 trans_complete_o,
  output logic                                 backend_idle_o
);

  logic [BurstWidth-1:0] cut_data;
  logic [AddrWidth-1:0]  cut_src, cut_dst, split_src, split_dst;
  logic [LenWidth-1:0]   cut_len, split_len;
  logic                  cut_valid, cut_ready, split_last, split_valid, split_ready;
  logic                  piece_done, piece_last_done, piece_idle;
  logic                  trans_complete, backend_idle;
  logic [NumGroups-1:0][AddrWidth-1:0] dist_src, dist_dst;
  logic [NumGroups-1:0][LenWidth-1:0]  dist_len;
  logic [NumGroups-1:0]                dist_valid, dist_ready;
  logic [MetaWidth-1:0]  meta_d, meta_q;

  dma_req_cut #(
    .Width(BurstWidth)
  ) i_req_cut (
    .clk_i  (clk_i                                 ),
    .reset_i(reset_i                               ),
    .data_i ({src_addr_i, dst_addr_i, num_bytes_i}),
    .valid_i(req_valid_i                           ),
    .ready_o(req_ready_o                           ),
    .data_o (cut_data                              ),
    .valid_o(cut_valid                             ),
    .ready_i(cut_ready                             )
  );

  assign {cut_src, cut_dst, cut_len} = cut_data;

  dma_split_midend #(
    .TCDMBaseAddr(TCDMBaseAddr),
    .TCDMSize    (TCDMSize    )
  ) i_split_midend (
    .clk_i            (clk_i          ),
    .reset_i          (reset_i        ),
    .src_addr_i       (cut_src        ),
    .dst_addr_i       (cut_dst        ),
    .num_bytes_i      (cut_len        ),
    .valid_i          (cut_valid      ),
    .ready_o          (cut_ready      ),
    .src_addr_o       (split_src      ),
    .dst_addr_o       (split_dst      ),
    .num_bytes_o      (split_len      ),
    .last_o           (split_last     ),
    .valid_o          (split_valid    ),
    .ready_i          (split_ready    ),
    .piece_done_i     (piece_done     ),
    .piece_last_done_i(piece_last_done),
    .piece_idle_i     (piece_idle     ),
    .trans_complete_o (trans_complete ),
    .backend_idle_o   (backend_idle   )
  );

  dma_distributed_midend #(
    .TCDMBaseAddr  (TCDMBaseAddr  ),
    .TCDMSize      (TCDMSize      ),
    .TransFifoDepth(TransFifoDepth)
  ) i_distributed_midend (
    .clk_i            (clk_i          ),
    .reset_i          (reset_i        ),
    .src_addr_i       (split_src      ),
    .dst_addr_i       (split_dst      ),
    .num_bytes_i      (split_len      ),
    .last_i           (split_last     ),
    .valid_i          (split_valid    ),
    .ready_o          (split_ready    ),
    .grp_src_addr_o   (dist_src       ),
    .grp_dst_addr_o   (dist_dst       ),
    .grp_num_bytes_o  (dist_len       ),
    .grp_valid_o      (dist_valid     ),
    .grp_ready_i      (dist_ready     ),
    .grp_done_i       (grp_done_i     ),
    .piece_done_o     (piece_done     ),
    .piece_last_done_o(piece_last_done),
    .piece_idle_o     (piece_idle     )
  );

  for (genvar g = 0; g < NumGroups; g++) begin : gen_grp_cut
    logic [BurstWidth-1:0] grp_data;

    dma_req_cut #(
      .Width(BurstWidth)
    ) i_grp_cut (
      .clk_i  (clk_i                                 ),
      .reset_i(reset_i                               ),
      .data_i ({dist_src[g], dist_dst[g], dist_len[g]}),
      .valid_i(dist_valid[g]                         ),
      .ready_o(dist_ready[g]                         ),
      .data_o (grp_data                              ),
      .valid_o(grp_valid_o[g]                        ),
      .ready_i(grp_ready_i[g]                        )
    );

    assign {grp_src_addr_o[g], grp_dst_addr_o[g], grp_num_bytes_o[g]} = grp_data;
  end

  // Meta leaves through one register
  always_comb begin
    meta_d                    = '0;
    meta_d[MetaTransComplete] = trans_complete;
    meta_d[MetaBackendIdle]   = backend_idle;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_q <= MetaResetValue;
    end else begin
      meta_q <= meta_d;
    end
  end

  assign trans_complete_o = meta_q[MetaTransComplete];
  assign backend_idle_o   = meta_q[MetaBackendIdle];

endmodule

// ==== src/dma/dma_distributed_midend.sv ====
// Hands each group its share of one region-bounded piece and tracks completion.
// Groups must report done in the order they accepted their sub-bursts.
module dma_distributed_midend
  import dma_pkg::*;
  import tcdm_pkg::*;
#(
  parameter logic [AddrWidth-1:0] TCDMBaseAddr   = 32'h0000_0000,
  parameter logic [AddrWidth-1:0] TCDMSize       = 32'h0001_0000,
  parameter int unsigned          TransFifoDepth = 8
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [AddrWidth-1:0]                 src_addr_i,
  input  logic [AddrWidth-1:0]                 dst_addr_i,
  input  logic [LenWidth-1:0]                  num_bytes_i,
  input  logic                                 last_i,
  input  logic                                 valid_i,
  output logic                                 ready_o,
  output logic [NumGroups-1:0][AddrWidth-1:0] grp_src_addr_o,
  output logic [NumGroups-1:0][AddrWidth-1:0] grp_dst_addr_o,
  output logic [NumGroups-1:0][LenWidth-1:0]  grp_num_bytes_o,
  output logic [NumGroups-1:0]                 grp_valid_o,
  input  logic [NumGroups-1:0]                 grp_ready_i,
  input  logic [NumGroups-1:0]                 grp_done_i,
  output logic                                 piece_done_o,
  output logic                                 piece_last_done_o,
  output logic                                 piece_idle_o
);

  localparam int unsigned PtrWidth     = (TransFifoDepth > 1) ? $clog2(TransFifoDepth) : 1;
  localparam int unsigned CntWidth     = $clog2(TransFifoDepth + 1);
  // A group may finish before the rest of its piece is accepted
  localparam int unsigned DoneCntWidth = $clog2(TransFifoDepth + 2);

  logic                 has_tcdm, dst_in_tcdm;
  tcdm_addr_u           tcdm_addr;
  logic [AddrWidth-1:0] piece_end;
  logic [NumGroups-1:0] involved, sent_q, taken, pending, head_mask;
  logic                 push, retire, fifo_full, fifo_empty, head_last;

  logic [NumGroups-1:0]    fifo_mask_q [TransFifoDepth];
  logic                    fifo_last_q [TransFifoDepth];
  logic [PtrWidth-1:0]     wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0]     fifo_cnt_q;
  logic [DoneCntWidth-1:0] done_cnt_q [NumGroups];

  assign dst_in_tcdm    = (dst_addr_i - TCDMBaseAddr) < TCDMSize;
  assign has_tcdm       = dst_in_tcdm || ((src_addr_i - TCDMBaseAddr) < TCDMSize);
  assign tcdm_addr.flat = dst_in_tcdm ? dst_addr_i : src_addr_i;
  assign piece_end      = tcdm_addr.flat + AddrWidth'(num_bytes_i);

  // Overlap of the piece with each group window of the same region
  always_comb begin
    tcdm_addr_u           win;
    logic [AddrWidth-1:0] win_end, sub_start, sub_end, sub_off;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      win.fields.region = tcdm_addr.fields.region;
      win.fields.group  = GroupIdxWidth'(g);
      win.fields.bank   = '0;
      win.fields.offset = '0;
      win_end   = win.flat + AddrWidth'(GroupRegionBytes);
      sub_start = (tcdm_addr.flat > win.flat) ? tcdm_addr.flat : win.flat;
      sub_end   = (piece_end < win_end) ? piece_end : win_end;
      sub_off   = sub_start - tcdm_addr.flat;
      involved[g]        = has_tcdm ? (sub_start < sub_end) : (g == 0);
      grp_num_bytes_o[g] = has_tcdm ? LenWidth'(sub_end - sub_start) : num_bytes_i;
      grp_src_addr_o[g]  = src_addr_i + (has_tcdm ? sub_off : '0);
      grp_dst_addr_o[g]  = dst_addr_i + (has_tcdm ? sub_off : '0);
    end
  end

  assign grp_valid_o = {NumGroups{valid_i && !fifo_full}} & involved & ~sent_q;
  assign taken       = sent_q | (grp_valid_o & grp_ready_i) | ~involved;
  assign ready_o     = !fifo_full && (&taken);
  assign push        = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i || push) begin
      sent_q <= '0;
    end else begin
      sent_q <= sent_q | (grp_valid_o & grp_ready_i);
    end
  end

  assign fifo_full  = fifo_cnt_q == CntWidth'(TransFifoDepth);
  assign fifo_empty = fifo_cnt_q == '0;
  assign head_mask  = fifo_mask_q[rd_ptr_q];
  assign head_last  = fifo_last_q[rd_ptr_q];

  for (genvar g = 0; g < NumGroups; g++) begin : gen_pending
    assign pending[g] = (done_cnt_q[g] != '0) || grp_done_i[g];
  end

  assign retire = !fifo_empty && (&(~head_mask | pending));

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mask_q[wr_ptr_q] <= involved;
      fifo_last_q[wr_ptr_q] <= last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
      for (int unsigned g = 0; g < NumGroups; g++) begin
        done_cnt_q[g] <= '0;
      end
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(TransFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (retire) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(TransFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + CntWidth'(push) - CntWidth'(retire);
      for (int unsigned g = 0; g < NumGroups; g++) begin
        done_cnt_q[g] <= done_cnt_q[g] + DoneCntWidth'(grp_done_i[g])
                         - DoneCntWidth'(retire && head_mask[g]);
      end
    end
  end

  assign piece_done_o      = retire;
  assign piece_last_done_o = head_last;
  assign piece_idle_o      = fifo_empty;

endmodule

// ==== src/dma/dma_split_midend.sv ====
// Cuts a burst at every cluster region boundary of its TCDM-side address.
// Zero-length bursts are not handled. Without a TCDM side the burst passes whole.
module dma_split_midend
  import dma_pkg::*;
  import tcdm_pkg::*;
#(
  parameter logic [AddrWidth-1:0] TCDMBaseAddr = 32'h0000_0000,
  parameter logic [AddrWidth-1:0] TCDMSize     = 32'h0001_0000
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Burst in
  input  logic [AddrWidth-1:0] src_addr_i,
  input  logic [AddrWidth-1:0] dst_addr_i,
  input  logic [LenWidth-1:0]  num_bytes_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  // Pieces out
  output logic [AddrWidth-1:0] src_addr_o,
  output logic [AddrWidth-1:0] dst_addr_o,
  output logic [LenWidth-1:0]  num_bytes_o,
  output logic                 last_o,
  output logic                 valid_o,
  input  logic                 ready_i,
  // Meta
  input  logic                 piece_done_i,
  input  logic                 piece_last_done_i,
  input  logic                 piece_idle_i,
  output logic                 trans_complete_o,
  output logic                 backend_idle_o
);

  localparam int unsigned RegionOffWidth = $clog2(ClusterRegionBytes);

  logic                 busy_q;
  logic                 has_tcdm_q, tcdm_dst_q;
  logic [AddrWidth-1:0] src_q, dst_q;
  logic [LenWidth-1:0]  len_q;
  logic                 src_in_tcdm, dst_in_tcdm;
  tcdm_addr_u           tcdm_addr;
  logic [LenWidth-1:0]  to_boundary, piece_len;
  logic                 piece_out;

  // Wraps below the base, so one compare covers both bounds
  assign src_in_tcdm = (src_addr_i - TCDMBaseAddr) < TCDMSize;
  assign dst_in_tcdm = (dst_addr_i - TCDMBaseAddr) < TCDMSize;

  assign tcdm_addr.flat = tcdm_dst_q ? dst_q : src_q;
  assign to_boundary    = LenWidth'(ClusterRegionBytes)
                          - LenWidth'(tcdm_addr.flat[RegionOffWidth-1:0]);

  assign last_o    = !has_tcdm_q || (len_q <= to_boundary);
  assign piece_len = last_o ? len_q : to_boundary;
  assign piece_out = valid_o && ready_i;

  assign valid_o     = busy_q;
  assign src_addr_o  = src_q;
  assign dst_addr_o  = dst_q;
  assign num_bytes_o = piece_len;

  // Next burst goes in as the last piece leaves
  assign ready_o = !busy_q || (piece_out && last_o);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else if (ready_o) begin
      busy_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      src_q      <= src_addr_i;
      dst_q      <= dst_addr_i;
      len_q      <= num_bytes_i;
      has_tcdm_q <= src_in_tcdm || dst_in_tcdm;
      tcdm_dst_q <= dst_in_tcdm;
    end else if (piece_out) begin
      src_q <= src_q + AddrWidth'(piece_len);
      dst_q <= dst_q + AddrWidth'(piece_len);
      len_q <= len_q - piece_len;
    end
  end

  assign trans_complete_o = piece_done_i && piece_last_done_i;
  assign backend_idle_o   = !busy_q && piece_idle_i;

endmodule

// ==== src/dma_req_cut.sv ====
// Two-entry spill register, full throughput, one cycle of latency.
// Neither ready nor data has a combinational path from input to output.
module dma_req_cut #(
  parameter int unsigned Width = 32
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [Width-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic [Width-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i
);

  logic [Width-1:0] a_data_q, b_data_q;
  logic             a_full_q, b_full_q;
  logic             a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  // A moves into B only when the output stalls
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B always holds the older entry
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = !a_full_q || !b_full_q;

endmodule

// ==== common/tcdm_pkg.sv ====
// TCDM address map of the cluster, groups interleaved on GroupRegionBytes.
// The TCDM base must be aligned to ClusterRegionBytes for the fields to hold.
package tcdm_pkg;
  import dma_pkg::*;

  localparam int unsigned BankBytes          = 4;
  localparam int unsigned NumGroups          = 4;
  localparam int unsigned NumBanksPerGroup   = 16;
  localparam int unsigned GroupRegionBytes   = NumBanksPerGroup * BankBytes;
  localparam int unsigned ClusterRegionBytes = NumGroups * GroupRegionBytes;

  localparam int unsigned ByteOffWidth   = $clog2(BankBytes);
  localparam int unsigned BankIdxWidth   = $clog2(NumBanksPerGroup);
  localparam int unsigned GroupIdxWidth  = $clog2(NumGroups);
  localparam int unsigned RegionIdxWidth = AddrWidth - GroupIdxWidth - BankIdxWidth
                                           - ByteOffWidth;

  // One address word, flat or split into its interleaving fields
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    struct packed {
      logic [RegionIdxWidth-1:0] region;
      logic [GroupIdxWidth-1:0]  group;
      logic [BankIdxWidth-1:0]   bank;
      logic [ByteOffWidth-1:0]   offset;
    } fields;
  } tcdm_addr_u;

endpackage

// ==== common/dma_pkg.sv ====
// Burst field widths and the meta encoding used by every DMA stage.
// A burst is packed as {src, dst, num_bytes} with src in the upper bits.
package dma_pkg;

  // Byte address width of both sides
  localparam int unsigned AddrWidth = 32;

  // Byte count of one burst, zero is not a legal value
  localparam int unsigned LenWidth = 16;

  // One packed burst as it travels through the spill registers
  localparam int unsigned BurstWidth = 2 * AddrWidth + LenWidth;

  // Meta word bit positions
  localparam int unsigned MetaWidth         = 2;
  localparam int unsigned MetaTransComplete = 0;
  localparam int unsigned MetaBackendIdle   = 1;

  // Idle and no completion pending after reset
  localparam logic [MetaWidth-1:0] MetaResetValue = 2'b10;

endpackage
